// File: dcache_pkg.sv
package dcache_pkg;

    // Word and line geometry
    localparam int word_size   = 32;
    localparam int line_bytes  = 16;
    localparam int line_size   = line_bytes * 8;
    localparam int n_lines     = 16;

    // Address split: tag | set | offset
    localparam int offset_size = 4;
    localparam int set_size    = 4;
    localparam int tag_size    = word_size - set_size - offset_size;

    // Store buffer depth and its pointer width
    localparam int sb_entries  = 4;
    localparam int sb_ptr_size = $clog2(sb_entries);

    // Pin counter must reach sb_entries, hence one extra bit
    localparam int pin_size    = 3;

    // Backing memory: response delay and number of lines held
    localparam int mem_latency    = 4;
    localparam int mem_lines      = 64;
    localparam int mem_index_size = $clog2(mem_lines);

    // Access size of a load or store
    typedef enum logic [0:0] {
        size_byte = 1'b0,
        size_word = 1'b1
    } size_e;

    // Request from the pipeline
    typedef struct packed {
        logic [word_size-1:0] addr;
        size_e                size;
        logic                 store;
        logic [word_size-1:0] wdata;
    } cpu_req_t;

    // One committed store waiting in the store buffer
    typedef struct packed {
        logic [word_size-1:0] addr;
        size_e                size;
        logic [word_size-1:0] value;
    } sb_entry_t;

    // Line read request, addr is line aligned
    typedef struct packed {
        logic [word_size-1:0] addr;
    } mem_req_t;

    // Line returned by memory
    typedef struct packed {
        logic [word_size-1:0] addr;
        logic [line_size-1:0] data;
    } mem_res_t;

    // Dirty line written back on eviction
    typedef struct packed {
        logic [word_size-1:0] addr;
        logic [line_size-1:0] data;
    } mem_wr_t;

endpackage

// File: dcache_core.sv
`timescale 1ns/10ps

module dcache_core (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req_valid,
    input  dcache_pkg::cpu_req_t                 req,
    input  logic                                 sb_valid,
    input  dcache_pkg::sb_entry_t                sb_head,
    input  logic                                 sb_same_set,
    input  logic                                 sb_full,
    input  logic                                 mem_res_valid,
    input  dcache_pkg::mem_res_t                 mem_res,
    output logic                                 stall,
    output logic                                 sb_done,
    output logic                                 hit_load,
    output logic [dcache_pkg::line_size-1:0]     line,
    output logic [dcache_pkg::offset_size-1:0]   offset,
    output dcache_pkg::size_e                    size,
    output logic                                 mem_req_valid,
    output dcache_pkg::mem_req_t                 mem_req,
    output logic                                 mem_wr_valid,
    output dcache_pkg::mem_wr_t                  mem_wr
);
    import dcache_pkg::*;

    // Line state
    logic [tag_size-1:0]  tags      [n_lines];
    logic [line_size-1:0] data      [n_lines];
    logic [pin_size-1:0]  pins      [n_lines];
    logic                 valid_q   [n_lines];
    logic                 dirty_q   [n_lines];

    // Miss request table, one slot per set
    logic                 mrq_valid [n_lines];
    logic [tag_size-1:0]  mrq_tag   [n_lines];
    logic [pin_size-1:0]  mrq_pins  [n_lines];

    // Address decode of the pipeline request
    logic [tag_size-1:0]    req_tag;
    logic [set_size-1:0]    req_set;
    logic [offset_size-1:0] req_offset;
    // Address decode of the store buffer head
    logic [tag_size-1:0]    sb_tag;
    logic [set_size-1:0]    sb_set;
    logic [offset_size-1:0] sb_offset;
    // Set of the returning line
    logic [tag_size-1:0]    res_tag;
    logic [set_size-1:0]    res_set;

    logic                 hit;
    logic                 mrq_busy;
    logic                 mrq_match;
    logic                 issue;
    logic                 store_ok;
    logic                 store_acc;
    logic                 store_hit;
    logic                 store_join;
    logic                 refill;
    logic [line_size-1:0] merged_line;

    assign req_offset = req.addr[offset_size-1:0];
    assign req_set    = req.addr[offset_size +: set_size];
    assign req_tag    = req.addr[word_size-1 -: tag_size];

    assign sb_offset  = sb_head.addr[offset_size-1:0];
    assign sb_set     = sb_head.addr[offset_size +: set_size];
    assign sb_tag     = sb_head.addr[word_size-1 -: tag_size];

    assign res_set    = mem_res.addr[offset_size +: set_size];
    assign res_tag    = mem_res.addr[word_size-1 -: tag_size];

    // Tag compare against the installed line
    assign hit       = valid_q[req_set] && (tags[req_set] == req_tag);
    assign mrq_busy  = mrq_valid[req_set];
    assign mrq_match = mrq_busy && (mrq_tag[req_set] == req_tag);

    // New miss only when the slot is free and the victim is not pinned
    assign issue = req_valid && !hit && !mrq_busy && (pins[req_set] == '0);

    // A store may hit a line only if that line is not about to be replaced
    assign store_ok = (hit && !mrq_busy) || mrq_match || issue;

    always_comb begin
        stall = 1'b0;
        if (req_valid) begin
            if (req.store) begin
                stall = sb_full || !store_ok;
            end else begin
                // No forwarding, wait for buffered stores to this set
                stall = !hit || sb_same_set;
            end
        end
    end

    assign store_acc  = req_valid && req.store && !stall;
    assign store_hit  = store_acc && hit && !mrq_busy;
    assign store_join = store_acc && mrq_match;

    // Towards the result stage
    assign hit_load = req_valid && !req.store && !stall;
    assign line     = data[req_set];
    assign offset   = req_offset;
    assign size     = req.size;

    // Miss request goes out in the first cycle the access is seen
    assign mem_req_valid = issue;
    assign mem_req.addr  = {req_tag, req_set, {offset_size{1'b0}}};

    // Response always matches an open slot of its set
    assign refill = mem_res_valid && mrq_valid[res_set];

    // Victim goes back to memory in the refill cycle if it was written
    assign mem_wr_valid = refill && valid_q[res_set] && dirty_q[res_set];
    assign mem_wr.addr  = {tags[res_set], res_set, {offset_size{1'b0}}};
    assign mem_wr.data  = data[res_set];

    // Head store drains as soon as its line sits in the cache
    assign sb_done = sb_valid && valid_q[sb_set] && (tags[sb_set] == sb_tag);

    // Merge the head store into its line
    always_comb begin
        merged_line = data[sb_set];
        if (sb_head.size == size_byte) begin
            merged_line[{sb_offset, 3'b000} +: 8] = sb_head.value[7:0];
        end else begin
            merged_line[{sb_offset[offset_size-1:2], 5'b00000} +: word_size] = sb_head.value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < n_lines; i++) begin
                tags[i]      <= '0;
                data[i]      <= '0;
                pins[i]      <= '0;
                valid_q[i]   <= 1'b0;
                dirty_q[i]   <= 1'b0;
                mrq_valid[i] <= 1'b0;
                mrq_tag[i]   <= '0;
                mrq_pins[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < n_lines; i++) begin
                if (refill && res_set == i) begin
                    // Install the line, it inherits the pins gathered while in flight
                    tags[i]      <= res_tag;
                    data[i]      <= mem_res.data;
                    valid_q[i]   <= 1'b1;
                    dirty_q[i]   <= 1'b0;
                    pins[i]      <= mrq_pins[i] + pin_size'(store_join && req_set == i);
                    mrq_valid[i] <= 1'b0;
                    mrq_pins[i]  <= '0;
                end else begin
                    // Store hit pins, drain unpins
                    pins[i] <= pins[i] + pin_size'(store_hit && req_set == i)
                               - pin_size'(sb_done && sb_set == i);
                    if (sb_done && sb_set == i) begin
                        data[i]    <= merged_line;
                        dirty_q[i] <= 1'b1;
                    end
                    if (issue && req_set == i) begin
                        mrq_valid[i] <= 1'b1;
                        mrq_tag[i]   <= req_tag;
                        // A load brings the line unpinned
                        mrq_pins[i]  <= pin_size'(store_acc);
                    end else if (store_join && req_set == i) begin
                        mrq_pins[i] <= mrq_pins[i] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: store_buffer.sv
`timescale 1ns/10ps

module store_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push,
    input  dcache_pkg::sb_entry_t             push_entry,
    input  logic                              pop,
    input  logic [dcache_pkg::set_size-1:0]   query_set,
    output dcache_pkg::sb_entry_t             head,
    output logic                              head_valid,
    output logic                              full,
    output logic                              same_set
);
    import dcache_pkg::*;

    // Entry storage, no reset on payload
    sb_entry_t              entries [sb_entries];
    // Occupancy per slot
    logic [sb_entries-1:0]  used;
    logic [sb_ptr_size-1:0] wr_ptr;
    logic [sb_ptr_size-1:0] rd_ptr;

    assign head       = entries[rd_ptr];
    assign head_valid = used[rd_ptr];
    assign full       = &used;

    // Any buffered store landing in the queried set
    always_comb begin
        same_set = 1'b0;
        for (int i = 0; i < sb_entries; i++) begin
            if (used[i] && entries[i].addr[offset_size +: set_size] == query_set) begin
                same_set = 1'b1;
            end
        end
    end

    // Payload write at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            used   <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // Caller never pushes into a full buffer
            if (push) begin
                used[wr_ptr] <= 1'b1;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            // Pop and push never touch the same slot
            if (pop && head_valid) begin
                used[rd_ptr] <= 1'b0;
                rd_ptr       <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: load_align.sv
`timescale 1ns/10ps

module load_align (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                hit_load,
    input  logic [dcache_pkg::line_size-1:0]    line,
    input  logic [dcache_pkg::offset_size-1:0]  offset,
    input  dcache_pkg::size_e                   size,
    output logic                                load_valid,
    output logic [dcache_pkg::word_size-1:0]    load_data
);
    import dcache_pkg::*;

    logic [7:0]           sel_byte;
    logic [word_size-1:0] sel_word;
    logic [word_size-1:0] aligned;

    // Byte at any offset, word on a 4-byte boundary
    assign sel_byte = line[{offset, 3'b000} +: 8];
    assign sel_word = line[{offset[offset_size-1:2], 5'b00000} +: word_size];

    // Bytes are sign extended
    assign aligned = (size == size_byte) ? {{(word_size-8){sel_byte[7]}}, sel_byte} : sel_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= hit_load;
        end
    end

    // Data only moves on a hit
    always_ff @(posedge clk) begin
        if (hit_load) begin
            load_data <= aligned;
        end
    end

endmodule

// File: line_memory.sv
`timescale 1ns/10ps

module line_memory (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  dcache_pkg::mem_req_t  req,
    input  logic                  wr_valid,
    input  dcache_pkg::mem_wr_t   wr,
    output logic                  res_valid,
    output dcache_pkg::mem_res_t  res
);
    import dcache_pkg::*;

    // Backing store covering the low 1 KiB
    logic [line_size-1:0]       mem [mem_lines];

    // Read pipeline, one stage per cycle of latency
    logic [mem_latency-1:0]     pipe_valid;
    mem_req_t                   pipe_req [mem_latency];

    logic [mem_index_size-1:0]  wr_index;
    logic [mem_index_size-1:0]  rd_index;

    assign wr_index = wr.addr[offset_size +: mem_index_size];
    assign rd_index = pipe_req[mem_latency-1].addr[offset_size +: mem_index_size];

    // Oldest stage answers, array read late so write-backs are seen
    assign res_valid = pipe_valid[mem_latency-1];
    assign res.addr  = pipe_req[mem_latency-1].addr;
    assign res.data  = mem[rd_index];

    // Array contents, known pattern at reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < mem_lines; l++) begin
                for (int b = 0; b < line_bytes; b++) begin
                    // Low byte of the byte address, scrambled
                    mem[l][b*8 +: 8] <= 8'(l * line_bytes + b) ^ 8'h5a;
                end
            end
        end else if (wr_valid) begin
            mem[wr_index] <= wr.data;
        end
    end

    // Valid bits of the pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[mem_latency-2:0], req_valid};
        end
    end

    // Addresses shift along with their valid bits
    always_ff @(posedge clk) begin
        pipe_req[0] <= req;
        for (int s = 1; s < mem_latency; s++) begin
            pipe_req[s] <= pipe_req[s-1];
        end
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/10ps

module dcache_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              req_valid,
    input  dcache_pkg::cpu_req_t              req,
    output logic                              stall,
    output logic                              load_valid,
    output logic [dcache_pkg::word_size-1:0]  load_data,
    output logic                              sb_full
);
    import dcache_pkg::*;

    // Store buffer side
    sb_entry_t              sb_head;
    sb_entry_t              sb_push_entry;
    logic                   sb_valid;
    logic                   sb_done;
    logic                   sb_same_set;
    logic                   sb_push;
    // Result stage side
    logic                   hit_load;
    logic [line_size-1:0]   line;
    logic [offset_size-1:0] offset;
    size_e                  size;
    // Memory side
    logic                   mem_req_valid;
    mem_req_t               mem_req;
    logic                   mem_res_valid;
    mem_res_t               mem_res;
    logic                   mem_wr_valid;
    mem_wr_t                mem_wr;

    // Accepted store enters the buffer in the same cycle
    assign sb_push       = req_valid && req.store && !stall;
    assign sb_push_entry = '{addr: req.addr, size: req.size, value: req.wdata};

    dcache_core u_core (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .sb_valid      (sb_valid),
        .sb_head       (sb_head),
        .sb_same_set   (sb_same_set),
        .sb_full       (sb_full),
        .mem_res_valid (mem_res_valid),
        .mem_res       (mem_res),
        .stall         (stall),
        .sb_done       (sb_done),
        .hit_load      (hit_load),
        .line          (line),
        .offset        (offset),
        .size          (size),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_wr_valid  (mem_wr_valid),
        .mem_wr        (mem_wr)
    );

    store_buffer u_sb (
        .clk        (clk),
        .rst        (rst),
        .push       (sb_push),
        .push_entry (sb_push_entry),
        .pop        (sb_done),
        .query_set  (req.addr[offset_size +: set_size]),
        .head       (sb_head),
        .head_valid (sb_valid),
        .full       (sb_full),
        .same_set   (sb_same_set)
    );

    load_align u_align (
        .clk        (clk),
        .rst        (rst),
        .hit_load   (hit_load),
        .line       (line),
        .offset     (offset),
        .size       (size),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

    line_memory u_mem (
        .clk       (clk),
        .rst       (rst),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .wr_valid  (mem_wr_valid),
        .wr        (mem_wr),
        .res_valid (mem_res_valid),
        .res       (mem_res)
    );

endmodule

// File: tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache;
    import dcache_pkg::*;

    // Random part of the table
    localparam int n_random = 40;

    logic                 clk;
    logic                 rst;
    logic                 req_valid;
    cpu_req_t             req;
    logic                 stall;
    logic                 load_valid;
    logic [word_size-1:0] load_data;
    logic                 sb_full;

    // Stimulus table with its expected load values
    string                names   [$];
    cpu_req_t             reqs    [$];
    logic [word_size-1:0] expects [$];

    // Accepted loads waiting for load_valid
    string                wait_names [$];
    logic [word_size-1:0] wait_data  [$];
    string                got_name;
    logic [word_size-1:0] want;

    // Load accepted on the last rising edge, result due now
    bit                   load_due  = 1'b0;
    // Store buffer seen full at least once
    bit                   full_seen = 1'b0;

    // Byte model of the low 1 KiB
    logic [7:0]           ref_mem [1024];

    integer seed = 1758;
    int     mismatches  = 0;
    int     failures    = 0;
    int     loads_sent  = 0;
    int     load_pulses = 0;
    int     cycles      = 0;
    int     cycle_limit = 0;

    dcache_top DUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .stall      (stall),
        .load_valid (load_valid),
        .load_data  (load_data),
        .sb_full    (sb_full)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task add_entry(input string name, input logic store, input size_e acc_size,
                   input logic [word_size-1:0] addr, input logic [word_size-1:0] wdata);
        cpu_req_t r;
        r.addr  = addr;
        r.size  = acc_size;
        r.store = store;
        r.wdata = wdata;
        names.push_back(name);
        reqs.push_back(r);
        // Filled in later by the model
        expects.push_back('0);
    endtask

    task add_directed();
        // Cold lines straight from memory
        add_entry("cold_word_0", 1'b0, size_word, 32'h000, 32'h0);
        add_entry("cold_word_1", 1'b0, size_word, 32'h00c, 32'h0);
        // Init bytes with bit 7 set
        add_entry("sext_byte_0", 1'b0, size_byte, 32'h0d0, 32'h0);
        add_entry("sext_byte_1", 1'b0, size_byte, 32'h0f5, 32'h0);
        add_entry("sext_byte_2", 1'b0, size_byte, 32'h1a3, 32'h0);
        // Store then load back, byte lands inside the stored word's line
        add_entry("st_word", 1'b1, size_word, 32'h040, 32'hdeadbeef);
        add_entry("st_byte", 1'b1, size_byte, 32'h045, 32'h00000080);
        add_entry("ld_word_after_st", 1'b0, size_word, 32'h040, 32'h0);
        add_entry("ld_byte_after_st", 1'b0, size_byte, 32'h045, 32'h0);
        add_entry("ld_word_merged", 1'b0, size_word, 32'h044, 32'h0);
        // 0x120 and 0x220 share set 2, so B evicts a dirty A
        add_entry("evict_st_a", 1'b1, size_word, 32'h120, 32'h12345678);
        add_entry("evict_st_a_byte", 1'b1, size_byte, 32'h12f, 32'h0000007e);
        add_entry("evict_ld_b", 1'b0, size_word, 32'h220, 32'h0);
        add_entry("evict_ld_a", 1'b0, size_word, 32'h120, 32'h0);
        add_entry("evict_ld_a_byte", 1'b0, size_byte, 32'h12f, 32'h0);
        // Back to back store misses to sets 5, 6 and 7
        add_entry("overlap_st_0", 1'b1, size_word, 32'h350, 32'hcafef00d);
        add_entry("overlap_st_1", 1'b1, size_word, 32'h364, 32'h0badc0de);
        add_entry("overlap_st_2", 1'b1, size_byte, 32'h37b, 32'h000000c3);
        add_entry("overlap_ld_0", 1'b0, size_word, 32'h350, 32'h0);
        add_entry("overlap_ld_1", 1'b0, size_word, 32'h364, 32'h0);
        add_entry("overlap_ld_2", 1'b0, size_byte, 32'h37b, 32'h0);
        // Five store misses to cold sets, the fifth finds the buffer full
        add_entry("fill_st_0", 1'b1, size_word, 32'h280, 32'h11111111);
        add_entry("fill_st_1", 1'b1, size_word, 32'h290, 32'h22222222);
        add_entry("fill_st_2", 1'b1, size_word, 32'h2b0, 32'h33333333);
        add_entry("fill_st_3", 1'b1, size_word, 32'h2c0, 32'h44444444);
        add_entry("fill_st_4", 1'b1, size_byte, 32'h2e3, 32'h000000a5);
        add_entry("fill_ld_0", 1'b0, size_word, 32'h280, 32'h0);
        add_entry("fill_ld_4", 1'b0, size_byte, 32'h2e3, 32'h0);
    endtask

    task add_random();
        logic [word_size-1:0] addr;
        logic [word_size-1:0] wdata;
        logic                 store;
        size_e                acc_size;
        for (int i = 0; i < n_random; i++) begin
            addr     = $random(seed);
            addr     = addr & 32'h0000_03ff;
            wdata    = $random(seed);
            store    = wdata[0];
            acc_size = wdata[1] ? size_word : size_byte;
            // Words stay aligned
            if (acc_size == size_word) begin
                addr[1:0] = 2'b00;
            end
            wdata = $random(seed);
            add_entry($sformatf("rand_%0d", i), store, acc_size, addr, wdata);
        end
    endtask

    // Walk the table in order, little endian bytes
    task fill_expected();
        int a;
        for (int b = 0; b < 1024; b++) begin
            ref_mem[b] = 8'(b) ^ 8'h5a;
        end
        for (int i = 0; i < reqs.size(); i++) begin
            a = int'(reqs[i].addr[9:0]);
            if (reqs[i].store) begin
                if (reqs[i].size == size_byte) begin
                    ref_mem[a] = reqs[i].wdata[7:0];
                end else begin
                    for (int k = 0; k < 4; k++) begin
                        ref_mem[a+k] = reqs[i].wdata[8*k +: 8];
                    end
                end
            end else if (reqs[i].size == size_byte) begin
                expects[i] = {{24{ref_mem[a][7]}}, ref_mem[a]};
            end else begin
                expects[i] = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
            end
        end
    endtask

    // Drive one entry and hold it until the DUT takes it
    task apply_entry(input int idx);
        req_valid <= 1'b1;
        req       <= reqs[idx];
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        // Stall low here, so this edge accepts it
        @(posedge clk);
        if (!reqs[idx].store) begin
            wait_names.push_back(names[idx]);
            wait_data.push_back(expects[idx]);
            loads_sent++;
            load_due = 1'b1;
        end
    endtask

    task print_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d loads returned",
                 mismatches, failures, load_pulses, loads_sent);
    endtask

    // Load results, sampled away from the clock edge
    always @(negedge clk) begin
        // A full buffer holds off every store
        if (!rst && sb_full) begin
            full_seen = 1'b1;
            if (req_valid && req.store && !stall) begin
                $display("store accepted while the store buffer was full at %0t", $time);
                failures++;
            end
        end
        // Hit result shows one cycle after acceptance
        if (load_due && !load_valid) begin
            $display("load_valid missing one cycle after a load was accepted at %0t",
                     $time);
            failures++;
        end
        load_due = 1'b0;
        if (!rst && load_valid) begin
            load_pulses++;
            if (wait_data.size() == 0) begin
                $display("load_valid pulsed with no load outstanding at %0t", $time);
                failures++;
            end else begin
                got_name = wait_names.pop_front();
                want     = wait_data.pop_front();
                if (load_data !== want) begin
                    $display("mismatch %s: expected %08h, actual %08h",
                             got_name, want, load_data);
                    mismatches++;
                end
            end
        end
    end

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        add_directed();
        add_random();
        fill_expected();
        cycle_limit = reqs.size() * (mem_latency + 12);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < reqs.size(); i++) begin
            apply_entry(i);
        end
        req_valid <= 1'b0;
        // Last result shows one cycle after its acceptance
        repeat (2) @(negedge clk);
        if (load_pulses != loads_sent) begin
            $display("load_valid pulsed %0d times for %0d loads", load_pulses, loads_sent);
            failures++;
        end
        if (wait_data.size() != 0) begin
            $display("%0d loads never returned a result", wait_data.size());
            failures++;
        end
        if (!full_seen) begin
            $display("sb_full never went high although five stores were outstanding");
            failures++;
        end
        print_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verilog.f
dcache_pkg.sv
dcache_core.sv
store_buffer.sv
load_align.sv
line_memory.sv
dcache_top.sv
tb_dcache.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_dcache
FILELIST   := verilog.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
